//--- compile.f
vec_pkg.sv
mem_bus_pkg.sv
rf_ram.sv
burst_mem.sv
mem_bus_arbiter.sv
host_port.sv
rf_ldst.sv
vec_mem_top.sv
tb_vec_mem.sv

//--- Bender.yml
package:
  name: vec_mem

sources:
  - vec_pkg.sv
  - mem_bus_pkg.sv
  - rf_ram.sv
  - burst_mem.sv
  - mem_bus_arbiter.sv
  - host_port.sv
  - rf_ldst.sv
  - vec_mem_top.sv
  - target: test
    files:
      - tb_vec_mem.sv

//--- tb_vec_mem.sv
// Testbench for vec_mem_top that runs host and load/store traffic against a memory scoreboard
`timescale 1ns/1ps

module tb_vec_mem
    import vec_pkg::*;
    import mem_bus_pkg::*;
;

    localparam int WAIT_LIMIT = 2000;        // Cycles per wait
    localparam int RUN_LIMIT  = 400000;      // ns for the whole run

    logic      clk = 1'b0;
    logic      rst_n;
    logic      ldst_load_start;
    logic      ldst_store_start;
    mem_addr_t ldst_mem_addr;
    rf_addr_t  ldst_rf_addr;
    line_cnt_t ldst_line_num;
    logic      ldst_done;
    logic      host_req;
    logic      host_we;
    mem_addr_t host_addr;
    mem_data_t host_wdata;
    mem_data_t host_rdata;
    logic      host_done;

    mem_data_t   sb [MEM_WORDS];             // Expected memory contents
    mem_data_t   rf_sb [RF_LINES][BEATS_PER_LINE];
    mem_data_t   exp_rdata;
    mem_addr_t   chk_addr;
    logic        chk_rd;
    int          job_expect;                 // Line writes for a load, beats for a store
    int          moved;
    int          err_cnt;
    int          tests_run;
    int          tests_failed;
    logic [31:0] lfsr_state = 32'had90;

    always #2 clk = ~clk;

    vec_mem_top u_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .ldst_load_start  (ldst_load_start),
        .ldst_store_start (ldst_store_start),
        .ldst_mem_addr    (ldst_mem_addr),
        .ldst_rf_addr     (ldst_rf_addr),
        .ldst_line_num    (ldst_line_num),
        .ldst_done        (ldst_done),
        .host_req         (host_req),
        .host_we          (host_we),
        .host_addr        (host_addr),
        .host_wdata       (host_wdata),
        .host_rdata       (host_rdata),
        .host_done        (host_done)
    );

    //////////////////////////////////////////////////
    // Checkers
    //////////////////////////////////////////////////
    assign exp_rdata = sb[chk_addr];

    // Transfers made by the running job
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            moved <= 0;
        end else if ((ldst_load_start || ldst_store_start) && ldst_done) begin
            moved <= 0;
        end else if (u_dut.rf_we || (u_dut.m0_write && !u_dut.m0_waitrequest)) begin
            moved <= moved + 1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        host_done && chk_rd |-> host_rdata == exp_rdata)
    else begin
        $display("Mismatch host_rdata at %h: got %h expected %h",
                 $sampled(chk_addr), $sampled(host_rdata), $sampled(exp_rdata));
        err_cnt++;
    end

    // Accepted strobe drops done on the next cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        (ldst_load_start || ldst_store_start) && ldst_done |=> !ldst_done)
    else begin
        $display("ldst_done did not fall after an accepted start strobe");
        err_cnt++;
    end

    // Done only comes back once every transfer of the job is made
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ldst_done) |-> moved == job_expect)
    else begin
        $display("ldst_done rose after %0d of %0d transfers", $sampled(moved),
                 $sampled(job_expect));
        err_cnt++;
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////
    function automatic logic step_lfsr();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic mem_data_t random_word();
        mem_data_t w;
        w = '0;
        for (int i = 0; i < DATA_W; i++) begin
            w = {w[DATA_W-2:0], step_lfsr()};
        end
        return w;
    endfunction

    // Called on a rising edge, returns on the edge where host_done was seen
    task automatic host_access(input logic wr, input mem_addr_t a, input mem_data_t d);
        int cycles;
        host_req   <= 1'b1;
        host_we    <= wr;
        host_addr  <= a;
        host_wdata <= d;
        chk_rd     <= !wr;
        chk_addr   <= a;
        if (wr) begin
            sb[a] = d;
        end
        @(posedge clk);
        host_req <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (host_done !== 1'b1 && cycles < WAIT_LIMIT);
        if (host_done !== 1'b1) begin
            $display("Timeout: host %s at %h never finished", wr ? "write" : "read", a);
            err_cnt++;
        end
    endtask

    task automatic fill_words(input mem_addr_t base, input int count);
        for (int i = 0; i < count; i++) begin
            host_access(1'b1, base + mem_addr_t'(i), random_word());
        end
    endtask

    task automatic read_words(input mem_addr_t base, input int count);
        for (int i = 0; i < count; i++) begin
            host_access(1'b0, base + mem_addr_t'(i), '0);
        end
    endtask

    task automatic pulse_start(input logic load, input mem_addr_t ma, input rf_addr_t ra,
                               input line_cnt_t n);
        ldst_load_start  <= load;
        ldst_store_start <= !load;
        ldst_mem_addr    <= ma;
        ldst_rf_addr     <= ra;
        ldst_line_num    <= n;
        @(posedge clk);
        ldst_load_start  <= 1'b0;
        ldst_store_start <= 1'b0;
    endtask

    // Line i, beat b sits at word ma + 4*i + b
    task automatic start_job(input logic load, input mem_addr_t ma, input rf_addr_t ra,
                             input line_cnt_t n);
        mem_addr_t a;
        rf_addr_t  r;
        job_expect <= load ? int'(n) : int'(n) * BEATS_PER_LINE;
        for (int i = 0; i < int'(n); i++) begin
            r = rf_addr_t'(ra + i);
            for (int b = 0; b < BEATS_PER_LINE; b++) begin
                a = ma + mem_addr_t'(i * BEATS_PER_LINE + b);
                if (load) begin
                    rf_sb[r][b] = sb[a];
                end else begin
                    sb[a] = rf_sb[r][b];
                end
            end
        end
        pulse_start(load, ma, ra, n);
    endtask

    task automatic wait_job_done(input string what);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (ldst_done !== 1'b1 && cycles < WAIT_LIMIT);
        if (ldst_done !== 1'b1) begin
            $display("Timeout: %s job never raised ldst_done", what);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        tests_run++;
        if (err_cnt == errs_at_start) begin
            $display("%-16s pass", name);
        end else begin
            tests_failed++;
            $display("%-16s fail, %0d errors", name, err_cnt - errs_at_start);
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        int e;
        rst_n            = 1'b0;
        ldst_load_start  = 1'b0;
        ldst_store_start = 1'b0;
        ldst_mem_addr    = '0;
        ldst_rf_addr     = '0;
        ldst_line_num    = '0;
        host_req         = 1'b0;
        host_we          = 1'b0;
        host_addr        = '0;
        host_wdata       = '0;
        chk_rd           = 1'b0;
        chk_addr         = '0;
        job_expect       = 0;
        err_cnt          = 0;
        tests_run        = 0;
        tests_failed     = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        e = err_cnt;
        assert (ldst_done === 1'b1) else begin
            $display("Mismatch ldst_done: got %h expected %h", ldst_done, 1'b1);
            err_cnt++;
        end
        assert (host_done === 1'b0) else begin
            $display("Mismatch host_done: got %h expected %h", host_done, 1'b0);
            err_cnt++;
        end
        finish_test("reset_state", e);

        e = err_cnt;
        fill_words(10'h380, 16);
        read_words(10'h380, 16);
        finish_test("host_access", e);

        // Source at 0x000, copy at 0x100 through lines 0 to 7
        e = err_cnt;
        fill_words(10'h000, 32);
        start_job(1'b1, 10'h000, 6'd0, line_cnt_t'(8));
        wait_job_done("load");
        start_job(1'b0, 10'h100, 6'd0, line_cnt_t'(8));
        wait_job_done("store");
        read_words(10'h100, 32);
        finish_test("load_store", e);

        // Second strobe lands while busy and must leave 0x300 alone
        e = err_cnt;
        fill_words(10'h300, 16);
        start_job(1'b0, 10'h200, 6'd4, line_cnt_t'(4));
        pulse_start(1'b0, 10'h300, 6'd0, line_cnt_t'(4));
        wait_job_done("store");
        read_words(10'h200, 16);
        read_words(10'h300, 16);
        finish_test("done_timing", e);

        e = err_cnt;
        start_job(1'b0, 10'h180, 6'd0, line_cnt_t'(8));
        for (int i = 0; i < 8; i++) begin
            host_access(1'b1, 10'h340 + mem_addr_t'(i), random_word());
            host_access(1'b0, mem_addr_t'(i), '0);
        end
        wait_job_done("store");
        read_words(10'h180, 32);
        read_words(10'h340, 8);
        finish_test("contention", e);

        e = err_cnt;
        fill_words(10'h3f0, 4);
        start_job(1'b1, 10'h3f0, 6'd63, line_cnt_t'(1));
        wait_job_done("load");
        start_job(1'b0, 10'h3fc, 6'd63, line_cnt_t'(1));
        wait_job_done("store");
        read_words(10'h3fc, 4);
        finish_test("single_line", e);

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Hard stop in case a wait loop is never left
    initial begin
        #(RUN_LIMIT * 1ns);
        $display("Run stopped at the time limit");
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- vec_mem_top.sv
// Vector memory block top that ties the load/store engine and host port to shared burst memory
`timescale 1ns/1ps

module vec_mem_top
    import vec_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      ldst_load_start,
    input  logic      ldst_store_start,
    input  mem_addr_t ldst_mem_addr,
    input  rf_addr_t  ldst_rf_addr,
    input  line_cnt_t ldst_line_num,
    output logic      ldst_done,
    input  logic      host_req,
    input  logic      host_we,
    input  mem_addr_t host_addr,
    input  mem_data_t host_wdata,
    output mem_data_t host_rdata,
    output logic      host_done
);

    // Engine side of the bus
    logic      m0_read;
    logic      m0_write;
    mem_addr_t m0_addr;
    burst_t    m0_burstcount;
    mem_data_t m0_writedata;
    logic      m0_waitrequest;
    mem_data_t m0_readdata;
    logic      m0_readdatavalid;
    // Host side of the bus
    logic      m1_read;
    logic      m1_write;
    mem_addr_t m1_addr;
    burst_t    m1_burstcount;
    mem_data_t m1_writedata;
    logic      m1_waitrequest;
    mem_data_t m1_readdata;
    logic      m1_readdatavalid;
    // Memory side
    logic      s_read;
    logic      s_write;
    mem_addr_t s_addr;
    burst_t    s_burstcount;
    mem_data_t s_writedata;
    logic      s_waitrequest;
    mem_data_t s_readdata;
    logic      s_readdatavalid;
    // Register file
    rf_addr_t  rf_addr;
    logic      rf_we;
    logic      rf_re;
    rf_line_t  rf_data;
    rf_line_t  rf_q;

    rf_ldst u_ldst (
        .clk               (clk),
        .rst_n             (rst_n),
        .load_start        (ldst_load_start),
        .store_start       (ldst_store_start),
        .mem_addr_in       (ldst_mem_addr),
        .rf_addr_in        (ldst_rf_addr),
        .line_num          (ldst_line_num),
        .done              (ldst_done),
        .mem_read          (m0_read),
        .mem_write         (m0_write),
        .mem_addr          (m0_addr),
        .mem_burstcount    (m0_burstcount),
        .mem_writedata     (m0_writedata),
        .mem_waitrequest   (m0_waitrequest),
        .mem_readdata      (m0_readdata),
        .mem_readdatavalid (m0_readdatavalid),
        .rf_addr           (rf_addr),
        .rf_we             (rf_we),
        .rf_re             (rf_re),
        .rf_data           (rf_data),
        .rf_q              (rf_q)
    );

    host_port u_host (
        .clk               (clk),
        .rst_n             (rst_n),
        .req               (host_req),
        .we                (host_we),
        .addr              (host_addr),
        .wdata             (host_wdata),
        .rdata             (host_rdata),
        .done              (host_done),
        .mem_read          (m1_read),
        .mem_write         (m1_write),
        .mem_addr          (m1_addr),
        .mem_burstcount    (m1_burstcount),
        .mem_writedata     (m1_writedata),
        .mem_waitrequest   (m1_waitrequest),
        .mem_readdata      (m1_readdata),
        .mem_readdatavalid (m1_readdatavalid)
    );

    mem_bus_arbiter u_arb (
        .clk              (clk),
        .rst_n            (rst_n),
        .m0_read          (m0_read),
        .m0_write         (m0_write),
        .m0_addr          (m0_addr),
        .m0_burstcount    (m0_burstcount),
        .m0_writedata     (m0_writedata),
        .m0_waitrequest   (m0_waitrequest),
        .m0_readdata      (m0_readdata),
        .m0_readdatavalid (m0_readdatavalid),
        .m1_read          (m1_read),
        .m1_write         (m1_write),
        .m1_addr          (m1_addr),
        .m1_burstcount    (m1_burstcount),
        .m1_writedata     (m1_writedata),
        .m1_waitrequest   (m1_waitrequest),
        .m1_readdata      (m1_readdata),
        .m1_readdatavalid (m1_readdatavalid),
        .s_read           (s_read),
        .s_write          (s_write),
        .s_addr           (s_addr),
        .s_burstcount     (s_burstcount),
        .s_writedata      (s_writedata),
        .s_waitrequest    (s_waitrequest),
        .s_readdata       (s_readdata),
        .s_readdatavalid  (s_readdatavalid)
    );

    burst_mem u_mem (
        .clk           (clk),
        .rst_n         (rst_n),
        .read          (s_read),
        .write         (s_write),
        .addr          (s_addr),
        .burstcount    (s_burstcount),
        .writedata     (s_writedata),
        .waitrequest   (s_waitrequest),
        .readdata      (s_readdata),
        .readdatavalid (s_readdatavalid)
    );

    rf_ram u_rf (
        .clk  (clk),
        .addr (rf_addr),
        .we   (rf_we),
        .re   (rf_re),
        .data (rf_data),
        .q    (rf_q)
    );

endmodule

//--- rf_ldst.sv
// Load/store engine that copies whole register lines between burst memory and the register file
`timescale 1ns/1ps

module rf_ldst
    import vec_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      load_start,
    input  logic      store_start,
    input  mem_addr_t mem_addr_in,
    input  rf_addr_t  rf_addr_in,
    input  line_cnt_t line_num,
    output logic      done,
    output logic      mem_read,
    output logic      mem_write,
    output mem_addr_t mem_addr,
    output burst_t    mem_burstcount,
    output mem_data_t mem_writedata,
    input  logic      mem_waitrequest,
    input  mem_data_t mem_readdata,
    input  logic      mem_readdatavalid,
    output rf_addr_t  rf_addr,
    output logic      rf_we,
    output logic      rf_re,
    output rf_line_t  rf_data,
    input  rf_line_t  rf_q
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_CMD,
        S_RD_BEATS,
        S_RF_WRITE,
        S_RF_READ,
        S_WR_CMD,
        S_WR_BEATS
    } state_t;

    state_t    state;
    state_t    state_nxt;
    mem_addr_t mem_addr_q;
    rf_addr_t  rf_addr_q;
    line_cnt_t lines_left;
    mem_data_t line_buf [BEATS_PER_LINE];
    beat_idx_t beat_idx;
    logic      last_beat;
    logic      rf_pend;         // rf_q valid this cycle
    logic      start;
    logic      line_nxt;
    logic      beat_inc;
    logic      buf_ld_mem;
    logic      buf_ld_rf;

    assign start     = (load_start || store_start) && state == S_IDLE;
    assign last_beat = beat_idx == beat_idx_t'(BEATS_PER_LINE - 1);

    //////////////////////////////////////////////////
    // Job counters
    //////////////////////////////////////////////////
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            lines_left <= '0;
        end else if (start) begin
            lines_left <= line_num;
        end else if (line_nxt) begin
            lines_left <= lines_left - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mem_addr_q <= mem_addr_in;
            rf_addr_q  <= rf_addr_in;
        end else if (line_nxt) begin
            mem_addr_q <= mem_addr_q + mem_addr_t'(BEATS_PER_LINE);  // One line of words
            rf_addr_q  <= rf_addr_q + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Line buffer
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (buf_ld_rf) begin
            for (int i = 0; i < BEATS_PER_LINE; i++) begin
                line_buf[i] <= rf_q[i*DATA_W +: DATA_W];
            end
        end else if (buf_ld_mem) begin
            line_buf[beat_idx] <= mem_readdata;
        end
    end

    always_comb begin
        for (int i = 0; i < BEATS_PER_LINE; i++) begin
            rf_data[i*DATA_W +: DATA_W] = line_buf[i];
        end
    end

    assign mem_addr       = mem_addr_q;
    assign mem_burstcount = burst_t'(BEATS_PER_LINE);    // Always a full line
    assign mem_writedata  = line_buf[beat_idx];
    assign rf_addr        = rf_addr_q;
    assign done           = state == S_IDLE;

    //////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            beat_idx <= '0;
            rf_pend  <= 1'b0;
        end else begin
            state   <= state_nxt;
            rf_pend <= rf_re;
            if (beat_inc) begin
                beat_idx <= beat_idx + 1'b1;     // Wraps to 0 after the last beat
            end
        end
    end

    always_comb begin
        state_nxt  = state;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        rf_we      = 1'b0;
        rf_re      = 1'b0;
        line_nxt   = 1'b0;
        beat_inc   = 1'b0;
        buf_ld_mem = 1'b0;
        buf_ld_rf  = 1'b0;
        case (state)
            S_IDLE: begin
                if (load_start) begin
                    state_nxt = S_RD_CMD;
                end else if (store_start) begin
                    state_nxt = S_RF_READ;
                end
            end
            S_RD_CMD: begin
                mem_read = 1'b1;
                if (!mem_waitrequest) begin
                    state_nxt = S_RD_BEATS;
                end
            end
            S_RD_BEATS: begin
                if (mem_readdatavalid) begin
                    buf_ld_mem = 1'b1;
                    beat_inc   = 1'b1;
                    if (last_beat) begin
                        state_nxt = S_RF_WRITE;
                    end
                end
            end
            S_RF_WRITE: begin
                rf_we     = 1'b1;
                line_nxt  = 1'b1;
                state_nxt = (lines_left == 1) ? S_IDLE : S_RD_CMD;
            end
            S_RF_READ: begin
                // First cycle reads the RAM, second captures the line
                rf_re     = !rf_pend;
                buf_ld_rf = rf_pend;
                if (rf_pend) begin
                    state_nxt = S_WR_CMD;
                end
            end
            S_WR_CMD: begin
                mem_write = 1'b1;                // Beat 0 rides with the command
                if (!mem_waitrequest) begin
                    beat_inc  = 1'b1;
                    state_nxt = S_WR_BEATS;
                end
            end
            S_WR_BEATS: begin
                mem_write = 1'b1;
                if (!mem_waitrequest) begin
                    beat_inc = 1'b1;
                    if (last_beat) begin
                        line_nxt  = 1'b1;
                        state_nxt = (lines_left == 1) ? S_IDLE : S_RF_READ;
                    end
                end
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    // Control unit never asks for both directions at once
    assert property (@(posedge clk) disable iff (!rst_n) !(load_start && store_start));

    // Beat index rests at zero between jobs
    assert property (@(posedge clk) disable iff (!rst_n)
        state == S_IDLE |-> beat_idx == '0);

endmodule

//--- host_port.sv
// Host-side master that turns single-word read/write requests into one-beat memory bus commands
`timescale 1ns/1ps

module host_port
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req,
    input  logic      we,
    input  mem_addr_t addr,
    input  mem_data_t wdata,
    output mem_data_t rdata,
    output logic      done,
    output logic      mem_read,
    output logic      mem_write,
    output mem_addr_t mem_addr,
    output burst_t    mem_burstcount,
    output mem_data_t mem_writedata,
    input  logic      mem_waitrequest,
    input  mem_data_t mem_readdata,
    input  logic      mem_readdatavalid
);

    typedef enum logic [1:0] {
        H_IDLE,
        H_CMD,
        H_WAIT
    } state_t;

    state_t state;
    logic   we_q;

    always_ff @(posedge clk) begin
        if (req && state == H_IDLE) begin
            we_q          <= we;
            mem_addr      <= addr;
            mem_writedata <= wdata;
        end
        if (state == H_WAIT && mem_readdatavalid) begin
            rdata <= mem_readdata;
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state <= H_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                H_IDLE: begin
                    if (req) begin
                        state <= H_CMD;
                    end
                end
                H_CMD: begin
                    if (!mem_waitrequest) begin
                        state <= we_q ? H_IDLE : H_WAIT;
                        done  <= we_q;           // Writes finish on acceptance
                    end
                end
                H_WAIT: begin
                    if (mem_readdatavalid) begin
                        state <= H_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= H_IDLE;
            endcase
        end
    end

    assign mem_read       = state == H_CMD && !we_q;
    assign mem_write      = state == H_CMD && we_q;
    assign mem_burstcount = burst_t'(1);

    // Outside waits for done before the next request
    assert property (@(posedge clk) disable iff (!rst_n) req |-> state == H_IDLE);

endmodule

//--- mem_bus_arbiter.sv
// Two-master round-robin arbiter for the memory bus that keeps the grant for a whole burst
`timescale 1ns/1ps

module mem_bus_arbiter
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // Load/store engine
    input  logic      m0_read,
    input  logic      m0_write,
    input  mem_addr_t m0_addr,
    input  burst_t    m0_burstcount,
    input  mem_data_t m0_writedata,
    output logic      m0_waitrequest,
    output mem_data_t m0_readdata,
    output logic      m0_readdatavalid,
    // Host port
    input  logic      m1_read,
    input  logic      m1_write,
    input  mem_addr_t m1_addr,
    input  burst_t    m1_burstcount,
    input  mem_data_t m1_writedata,
    output logic      m1_waitrequest,
    output mem_data_t m1_readdata,
    output logic      m1_readdatavalid,
    // Memory
    output logic      s_read,
    output logic      s_write,
    output mem_addr_t s_addr,
    output burst_t    s_burstcount,
    output mem_data_t s_writedata,
    input  logic      s_waitrequest,
    input  mem_data_t s_readdata,
    input  logic      s_readdatavalid
);

    logic   req0;
    logic   req1;
    logic   pick;       // Master chosen on an idle bus
    logic   sel;        // Master currently forwarded
    logic   rr;         // 1 gives m1 priority
    logic   grant;
    burst_t due;        // Beats still owed in the held burst

    assign req0 = m0_read || m0_write;
    assign req1 = m1_read || m1_write;
    assign pick = req1 && (!req0 || rr);
    assign sel  = (due != '0) ? grant : pick;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            rr    <= 1'b0;
            grant <= 1'b0;
            due   <= '0;
        end else if (due == '0) begin
            if (req0 || req1) begin
                grant <= pick;
                rr    <= !pick;
                due   <= pick ? m1_burstcount : m0_burstcount;
            end
        end else if ((s_write && !s_waitrequest) || s_readdatavalid) begin
            due <= due - 1'b1;
        end
    end

    assign s_read       = sel ? m1_read       : m0_read;
    assign s_write      = sel ? m1_write      : m0_write;
    assign s_addr       = sel ? m1_addr       : m0_addr;
    assign s_burstcount = sel ? m1_burstcount : m0_burstcount;
    assign s_writedata  = sel ? m1_writedata  : m0_writedata;

    // Losing master just stalls
    assign m0_waitrequest   = sel ? 1'b1 : s_waitrequest;
    assign m1_waitrequest   = sel ? s_waitrequest : 1'b1;
    assign m0_readdatavalid = !sel && s_readdatavalid;
    assign m1_readdatavalid = sel && s_readdatavalid;
    assign m0_readdata      = s_readdata;
    assign m1_readdata      = s_readdata;

    // A burst is never split between masters, every beat lands under a held grant
    assert property (@(posedge clk) disable iff (!rst_n)
        (s_write && !s_waitrequest) || s_readdatavalid |-> due != '0);

endmodule

//--- burst_mem.sv
// On-chip burst memory slave standing in for SDRAM with a one-cycle command stall and read latency
`timescale 1ns/1ps

module burst_mem
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      read,
    input  logic      write,
    input  mem_addr_t addr,
    input  burst_t    burstcount,
    input  mem_data_t writedata,
    output logic      waitrequest,
    output mem_data_t readdata,
    output logic      readdatavalid
);

    mem_data_t               mem [MEM_WORDS];
    mem_data_t               pipe_data [READ_LATENCY];
    logic [READ_LATENCY-1:0] pipe_vld;
    mem_addr_t               burst_addr;
    mem_addr_t               beat_addr;
    burst_t                  beats_left;     // Beats after the first
    logic                    burst_rd;
    logic                    stalled;
    logic                    new_cmd;
    logic                    accept;
    logic                    wr_beat;
    logic                    rd_beat;

    //////////////////////////////////////////////////
    // Command and beat control
    //////////////////////////////////////////////////
    assign new_cmd     = (read || write) && beats_left == '0;
    assign waitrequest = new_cmd && !stalled;              // One stall per command
    assign accept      = new_cmd && stalled;
    assign wr_beat     = write && (accept || (beats_left != '0 && !burst_rd));
    assign rd_beat     = (read && accept) || (beats_left != '0 && burst_rd);
    assign beat_addr   = accept ? addr : burst_addr;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            stalled    <= 1'b0;
            beats_left <= '0;
            burst_rd   <= 1'b0;
            pipe_vld   <= '0;
        end else begin
            stalled  <= waitrequest;
            pipe_vld <= {pipe_vld[READ_LATENCY-2:0], rd_beat};
            if (accept) begin
                beats_left <= burstcount - 1'b1;
                burst_rd   <= read;
            end else if (wr_beat || rd_beat) begin
                beats_left <= beats_left - 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Storage and read delay line
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_beat) begin
            mem[beat_addr] <= writedata;
        end
        if (wr_beat || rd_beat) begin
            burst_addr <= beat_addr + 1'b1;
        end
        if (rd_beat) begin
            pipe_data[0] <= mem[beat_addr];
        end
        for (int i = 1; i < READ_LATENCY; i++) begin
            pipe_data[i] <= pipe_data[i-1];
        end
    end

    assign readdata      = pipe_data[READ_LATENCY-1];
    assign readdatavalid = pipe_vld[READ_LATENCY-1];

    // Arbiter holds the bus until a read burst has fully drained
    assert property (@(posedge clk) disable iff (!rst_n)
        (read || write) |-> pipe_vld == '0 && !(burst_rd && beats_left != '0));

endmodule

//--- rf_ram.sv
// Register-file line RAM written and read whole lines at a time by the load/store engine
`timescale 1ns/1ps

module rf_ram
    import vec_pkg::*;
(
    input  logic     clk,
    input  rf_addr_t addr,
    input  logic     we,
    input  logic     re,
    input  rf_line_t data,
    output rf_line_t q
);

    rf_line_t mem [RF_LINES];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= data;
        end
        if (re) begin
            q <= mem[addr];                  // Valid the cycle after re
        end
    end

endmodule

//--- mem_bus_pkg.sv
// Memory bus widths and burst geometry shared by every bus master, the arbiter and the memory
package mem_bus_pkg;

    //////////////////////////////////////////////////
    // Bus geometry
    //////////////////////////////////////////////////
    localparam int MEM_WORDS      = 1024;
    localparam int ADDR_W         = $clog2(MEM_WORDS);   // Word addressed
    localparam int DATA_W         = 32;
    localparam int BEATS_PER_LINE = 4;
    localparam int BURST_W        = $clog2(BEATS_PER_LINE) + 1;

    // Cycles from read acceptance to first readdatavalid
    localparam int READ_LATENCY   = 2;

    typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_idx_t;
    typedef logic [ADDR_W-1:0]                 mem_addr_t;
    typedef logic [DATA_W-1:0]                 mem_data_t;
    typedef logic [BURST_W-1:0]                burst_t;

endpackage

//--- vec_pkg.sv
// Register-file geometry and line types shared by the vector memory RTL and its testbench
package vec_pkg;

    //////////////////////////////////////////////////
    // Register file geometry
    //////////////////////////////////////////////////
    localparam int RF_LINES  = 64;
    localparam int RF_ADDR_W = $clog2(RF_LINES);
    localparam int LINE_W    = 128;                  // Four memory beats per line

    typedef logic [RF_ADDR_W-1:0] rf_addr_t;         // Register line index
    typedef logic [RF_ADDR_W:0]   line_cnt_t;        // Job length, 1 to RF_LINES
    typedef logic [LINE_W-1:0]    rf_line_t;         // Beat 0 in the low word

endpackage
